// File: sources.f
+incdir+dv
rtl/grn_net_pkg.sv
rtl/grn_job_pkg.sv
rtl/grn_sync_fifo.sv
rtl/grn_state_stepper.sv
rtl/grn_attractor_ctrl.sv
rtl/grn_attractor_top.sv
dv/grn_attractor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module grn_attractor_tb -o grn_sim \
  && ./obj_dir/grn_sim 2>&1 | tee sim.log \
  || { echo "simulation build or run failed"; exit 1; }

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

exit 0

// File: dv/grn_ref_model.svh
`ifndef GRN_REF_MODEL_SVH
`define GRN_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network update rule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Each node takes the vote of itself and its two ring neighbours, then the ring turns by one.
function automatic net_state_t ref_rule(input net_state_t s);
  net_state_t voted;
  int         left;
  int         right;
  int         votes;
  for (int i = 0; i < NODES; i++) begin
    left     = (i == 0) ? NODES - 1 : i - 1;
    right    = (i == NODES - 1) ? 0 : i + 1;
    votes    = int'(s[left]) + int'(s[i]) + int'(s[right]);
    voted[i] = (votes >= 2);
  end
  return (voted << 1) | (voted >> (NODES - 1));  // top node wraps to node 0.
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// attractor search
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic attractor_result_t ref_result(input net_state_t start_state);
  net_state_t        slow;
  net_state_t        fast;
  net_state_t        probe;
  int                k;
  int                p;
  attractor_result_t r;
  slow = ref_rule(start_state);
  fast = ref_rule(ref_rule(start_state));
  k    = 1;
  while (slow != fast) begin
    slow = ref_rule(slow);
    fast = ref_rule(ref_rule(fast));
    k    = k + 1;  // smallest k where k steps equal 2k steps.
  end
  // the hare keeps its two rule steps per count while the period is measured.
  probe = ref_rule(ref_rule(slow));
  p     = 1;
  while (probe != slow) begin
    probe = ref_rule(ref_rule(probe));
    p     = p + 1;
  end
  r.meet_state = slow;
  r.transient  = (slow == start_state) ? '0 : count_t'(k);
  r.period     = count_t'(p);
  return r;
endfunction

`endif

// File: dv/grn_attractor_tb.sv
`timescale 1ns/1ps

module grn_attractor_tb import grn_net_pkg::*, grn_job_pkg::*;;

  localparam int N_SINGLE = 12;
  // fixed points, singles, one range of 16, three of 4, back-pressure 16, pause 8.
  localparam int N_STATES = 2 + N_SINGLE + 16 + 3 * 4 + 16 + 8;
  localparam int LIMIT    = N_STATES * 600 + 300;

  logic              clk;
  logic              rst;
  logic              start;
  state_range_t      job_data;
  logic              job_we;
  logic              job_full;
  logic              end_of_jobs;
  logic              result_re = 1'b0;
  attractor_result_t result_data;
  logic              result_empty;
  logic              done;

  int                seed = 70930;
  int                errors = 0;
  int                rx_count = 0;
  int                cycles = 0;
  logic              reader_on;
  logic              data_due = 1'b0;
  attractor_result_t exp_q [$];
  string             name_q [$];
  attractor_result_t exp_word;
  string             exp_name;

  `include "grn_ref_model.svh"

  grn_attractor_top #(.DEPTH_LOG2(3)) dut_i (
    .clk(clk), .rst(rst), .start(start),
    .job_data(job_data), .job_we(job_we), .job_full(job_full),
    .end_of_jobs(end_of_jobs), .result_re(result_re),
    .result_data(result_data), .result_empty(result_empty), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic net_state_t rand_state();
    return net_state_t'({$random(seed), $random(seed), $random(seed)});
  endfunction

  function automatic attractor_result_t fixed_point_result(input net_state_t s);
    attractor_result_t r;
    r.meet_state = s;
    r.transient  = '0;
    r.period     = count_t'(1);
    return r;
  endfunction

  task automatic send_job(input net_state_t first, input net_state_t last);
    @(posedge clk);
    while (job_full) @(posedge clk);
    job_data <= '{last_state: last, first_state: first};
    job_we   <= 1'b1;
    @(posedge clk);
    job_we <= 1'b0;  // one idle cycle lets job_full settle before the next write.
  endtask

  task automatic run_range(input string name, input net_state_t first, input net_state_t last);
    net_state_t s;
    s = first;
    forever begin
      exp_q.push_back(ref_result(s));
      name_q.push_back(name);
      if (s == last) break;
      s = s + net_state_t'(1);
    end
    send_job(first, last);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    net_state_t base;
    int         pause_len;
    logic       empty_snap;
    int         rx_snap;
    rst         <= 1'b1;
    start       <= 1'b0;
    job_data    <= '0;
    job_we      <= 1'b0;
    end_of_jobs <= 1'b0;
    reader_on   <= 1'b0;
    repeat (8) @(posedge clk);
    rst       <= 1'b0;
    start     <= 1'b1;
    reader_on <= 1'b1;

    exp_q.push_back(fixed_point_result('0));
    name_q.push_back("fixed_zero");
    send_job('0, '0);
    exp_q.push_back(fixed_point_result('1));
    name_q.push_back("fixed_ones");
    send_job('1, '1);
    for (int i = 0; i < N_SINGLE; i++) begin
      base = rand_state();
      run_range("single_random", base, base);
    end
    base = rand_state();
    base[NODES-1] = 1'b0;  // keeps every range clear of wrap-around.
    run_range("range_16", base, base + net_state_t'(15));
    for (int j = 0; j < 3; j++) begin
      base = rand_state();
      base[NODES-1] = 1'b0;
      run_range("back_to_back", base, base + net_state_t'(3));
    end

    base = rand_state();
    base[NODES-1] = 1'b0;
    run_range("backpressure", base, base + net_state_t'(15));
    reader_on <= 1'b0;
    while (!dut_i.result_full) @(posedge clk);
    repeat (20) @(posedge clk);
    if (!dut_i.result_full) begin
      errors = errors + 1;
      $display("error: output fifo lost words while the host was not reading");
    end
    reader_on <= 1'b1;

    base = rand_state();
    base[NODES-1] = 1'b0;
    run_range("pause", base, base + net_state_t'(7));
    repeat (40) @(posedge clk);
    pause_len = 10 + ($random(seed) & 31);
    start <= 1'b0;
    @(posedge clk);
    while (!result_empty) @(posedge clk);  // the reader drains what is left.
    repeat (2) @(posedge clk);
    empty_snap = result_empty;
    rx_snap    = rx_count;
    repeat (pause_len) begin
      @(posedge clk);
      if (result_empty !== empty_snap || rx_count != rx_snap) begin
        errors = errors + 1;
        $display("error: results moved while start was low");
      end
    end
    start <= 1'b1;

    end_of_jobs <= 1'b1;
    while (!done) @(posedge clk);
    repeat (3) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors = errors + 1;
      $display("error: %0d results never arrived", exp_q.size());
    end
    $display("errors: %0d, results checked: %0d", errors, rx_count);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reader and comparison
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (!rst) begin
      if (data_due) begin
        rx_count = rx_count + 1;
        if (exp_q.size() == 0) begin
          errors = errors + 1;
          $display("error: a result arrived when none was expected");
        end else begin
          exp_word = exp_q.pop_front();
          exp_name = name_q.pop_front();
          if (result_data !== exp_word) begin
            errors = errors + 1;
            $write("** Error %s: expected meet=%h trans=%0d per=%0d", exp_name,
                   exp_word.meet_state, exp_word.transient, exp_word.period);
            $display(", actual meet=%h trans=%0d per=%0d", result_data.meet_state,
                     result_data.transient, result_data.period);
          end
        end
      end
      data_due = result_re && !result_empty;  // data shows up after this edge.
      result_re <= reader_on && !result_empty && !result_re;
      if (done && !end_of_jobs) begin
        errors = errors + 1;
        $display("error: done rose before end_of_jobs");
      end
      if (done && !result_empty) begin
        errors = errors + 1;
        $display("error: done is high while results are still unread");
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      errors = errors + 1;
      $display("error: the engine never finished, done still low after %0d cycles", cycles);
      $display("errors: %0d, results checked: %0d", errors, rx_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

// File: rtl/grn_attractor_top.sv
`timescale 1ns/1ps

module grn_attractor_top import grn_net_pkg::*, grn_job_pkg::*; #(
  parameter int DEPTH_LOG2 = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  state_range_t      job_data,
  input  logic              job_we,
  output logic              job_full,
  input  logic              end_of_jobs,
  input  logic              result_re,
  output attractor_result_t result_data,
  output logic              result_empty,
  output logic              done
);

  localparam int JOB_W    = $bits(state_range_t);
  localparam int RESULT_W = $bits(attractor_result_t);

  state_range_t      job_word;
  logic              job_re;
  logic              job_empty;
  attractor_result_t result_word;
  logic              result_we;
  logic              result_full;
  logic              load;
  logic              advance_tortoise;
  logic              advance_hare;
  net_state_t        init_state;
  net_state_t        tortoise_state;
  net_state_t        hare_state;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host queues
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  grn_sync_fifo #(.WIDTH(JOB_W), .DEPTH_LOG2(DEPTH_LOG2)) job_fifo_i (
    .clk(clk), .rst(rst),
    .we(job_we), .wdata(job_data),
    .re(job_re), .rdata(job_word),
    .full(job_full), .empty(job_empty)
  );

  grn_sync_fifo #(.WIDTH(RESULT_W), .DEPTH_LOG2(DEPTH_LOG2)) result_fifo_i (
    .clk(clk), .rst(rst),
    .we(result_we), .wdata(result_word),
    .re(result_re), .rdata(result_data),
    .full(result_full), .empty(result_empty)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tortoise and hare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  grn_state_stepper #(.STEPS(1)) tortoise_i (
    .clk(clk), .rst(rst), .hold_n(start),
    .load(load), .advance(advance_tortoise),
    .init_state(init_state), .state(tortoise_state)
  );

  grn_state_stepper #(.STEPS(2)) hare_i (
    .clk(clk), .rst(rst), .hold_n(start),
    .load(load), .advance(advance_hare),
    .init_state(init_state), .state(hare_state)
  );

  grn_attractor_ctrl ctrl_i (
    .clk(clk), .rst(rst), .start(start), .end_of_jobs(end_of_jobs),
    .job_empty(job_empty), .job_word(job_word), .job_re(job_re),
    .tortoise_state(tortoise_state), .hare_state(hare_state),
    .load(load), .init_state(init_state),
    .advance_tortoise(advance_tortoise), .advance_hare(advance_hare),
    .result_full(result_full), .result_empty(result_empty),
    .result_we(result_we), .result_word(result_word), .done(done)
  );

endmodule

// File: rtl/grn_attractor_ctrl.sv
`timescale 1ns/1ps

module grn_attractor_ctrl import grn_net_pkg::*, grn_job_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              end_of_jobs,
  // input FIFO side.
  input  logic              job_empty,
  input  state_range_t      job_word,
  output logic              job_re,
  // steppers.
  input  net_state_t        tortoise_state,
  input  net_state_t        hare_state,
  output logic              load,
  output net_state_t        init_state,
  output logic              advance_tortoise,
  output logic              advance_hare,
  // output FIFO side.
  input  logic              result_full,
  input  logic              result_empty,
  output logic              result_we,
  output attractor_result_t result_word,
  output logic              done
);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    LOAD,
    SEARCH,
    MEASURE,
    EMIT,
    FINISH
  } fsm_t;

  fsm_t       fsm_q;
  net_state_t cur_state;   // initial state being worked on.
  net_state_t last_state;  // inclusive upper bound of the job.
  net_state_t meet_q;
  count_t     trans_cnt;
  count_t     per_cnt;
  logic       search_hit;
  logic       period_hit;
  logic       range_end;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compares
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Right after load both steppers hold the same state, so one advance has to come first.
  assign search_hit = (tortoise_state == hare_state) && (trans_cnt != '0);
  assign period_hit = (hare_state == meet_q) && (per_cnt != '0);
  assign range_end  = (cur_state >= last_state);

  assign init_state  = cur_state;
  assign result_word = '{meet_state: meet_q, transient: trans_cnt, period: per_cnt};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // strobes and enables
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    job_re           = 1'b0;
    load             = 1'b0;
    advance_tortoise = 1'b0;
    advance_hare     = 1'b0;
    result_we        = 1'b0;
    if (start) begin
      case (fsm_q)
        IDLE: begin
          job_re = !job_empty;
        end
        LOAD: begin
          load = 1'b1;
        end
        SEARCH: begin
          advance_tortoise = !search_hit;
          advance_hare     = !search_hit;
        end
        MEASURE: begin
          advance_hare = !period_hit;  // the tortoise rests here.
        end
        EMIT: begin
          result_we = !result_full;
        end
        default: begin
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing and counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_q     <= IDLE;
      trans_cnt <= '0;
      per_cnt   <= '0;
      done      <= 1'b0;
    end else if (start) begin
      case (fsm_q)
        IDLE: begin
          if (!job_empty) begin
            fsm_q <= FETCH;  // job_re is high this cycle.
          end else if (end_of_jobs) begin
            fsm_q <= FINISH;
          end
        end
        FETCH: begin
          cur_state  <= job_word.first_state;  // read data landed at the last edge.
          last_state <= job_word.last_state;
          fsm_q      <= LOAD;
        end
        LOAD: begin
          trans_cnt <= '0;
          per_cnt   <= '0;
          fsm_q     <= SEARCH;
        end
        SEARCH: begin
          if (search_hit) begin
            meet_q <= tortoise_state;
            // An initial state that already lies on its cycle has no transient.
            if (tortoise_state == cur_state) begin
              trans_cnt <= '0;
            end
            fsm_q <= MEASURE;
          end else begin
            trans_cnt <= trans_cnt + 1'b1;
          end
        end
        MEASURE: begin
          if (period_hit) begin
            fsm_q <= EMIT;
          end else begin
            per_cnt <= per_cnt + 1'b1;
          end
        end
        EMIT: begin
          if (!result_full) begin  // otherwise hold the result and wait.
            if (range_end) begin
              fsm_q <= IDLE;
            end else begin
              cur_state <= cur_state + net_state_t'(1);
              fsm_q     <= LOAD;
            end
          end
        end
        FINISH: begin
          if (!job_empty) begin
            fsm_q <= IDLE;
          end else if (end_of_jobs && result_empty) begin
            done <= 1'b1;  // sticky until reset.
          end
        end
        default: begin
          fsm_q <= IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_no_result_overflow: assert property (
    @(posedge clk) disable iff (rst) result_we |-> !result_full
  ) else $error("result written into a full output fifo.");

  // Both steppers must show the loaded state one edge after the pulse.
  a_load_seen: assert property (
    @(posedge clk) disable iff (rst)
    load |=> (tortoise_state == $past(init_state)) && (hare_state == $past(init_state))
  ) else $error("steppers did not take the loaded state.");

endmodule

// File: rtl/grn_state_stepper.sv
`timescale 1ns/1ps

module grn_state_stepper import grn_net_pkg::*; #(
  parameter int STEPS = 1
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       hold_n,
  input  logic       load,
  input  logic       advance,
  input  net_state_t init_state,
  output net_state_t state
);

  // Majority of each node and its two ring neighbours, then a rotate left by one.
  function automatic net_state_t rule_step(input net_state_t s);
    net_state_t maj;
    int         up;
    int         dn;
    for (int i = 0; i < NODES; i++) begin
      up     = (i + 1) % NODES;
      dn     = (i + NODES - 1) % NODES;
      maj[i] = (s[i] & s[up]) | (s[i] & s[dn]) | (s[up] & s[dn]);
    end
    return {maj[NODES-2:0], maj[NODES-1]};
  endfunction

  net_state_t chain [STEPS+1];  // chain[n] is the state after n rule steps.

  assign chain[0] = state;

  for (genvar g = 0; g < STEPS; g++) begin : g_step
    assign chain[g+1] = rule_step(chain[g]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '0;
    end else if (hold_n) begin
      if (load) begin
        state <= init_state;
      end else if (advance) begin
        state <= chain[STEPS];
      end
    end
  end

  // The controller owns both strobes, so a clash points at its FSM.
  a_load_xor_advance: assert property (@(posedge clk) disable iff (rst) !(load && advance))
    else $error("stepper got load and advance together.");

endmodule

// File: rtl/grn_sync_fifo.sv
`timescale 1ns/1ps

module grn_sync_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 3
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  logic [WIDTH-1:0] wdata,
  input  logic             re,
  output logic [WIDTH-1:0] rdata,
  output logic             full,
  output logic             empty
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;  // one bit wider than the pointers.
  logic                  do_write;
  logic                  do_read;

  assign full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));
  assign empty = (count == '0);

  assign do_write = we && !full;   // illegal strobes are dropped.
  assign do_read  = re && !empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage and read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wdata;
    end
    if (do_read) begin
      rdata <= mem[rd_ptr];  // valid the cycle after re.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps on its own at DEPTH.
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (do_read && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

  // The producer and consumer sit in other modules, so these catch their misuse.
  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst) we |-> !full)
    else $error("fifo written while full.");

  a_no_read_when_empty: assert property (@(posedge clk) disable iff (rst) re |-> !empty)
    else $error("fifo read while empty.");

endmodule

// File: rtl/grn_job_pkg.sv
package grn_job_pkg;

  import grn_net_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input job word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Both bounds are inclusive.
  typedef struct packed {
    net_state_t last_state;
    net_state_t first_state;
  } state_range_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output result word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one of these per initial state, 128 bits in all.
  typedef struct packed {
    net_state_t meet_state;  // where tortoise and hare met.
    count_t     transient;
    count_t     period;
  } attractor_result_t;

endpackage

// File: rtl/grn_net_pkg.sv
package grn_net_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // network size
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NODES = 70;    // nodes on the ring.

  // Wide enough for the longest transient or period we ever expect to count.
  localparam int COUNT_W = 29;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state and counter types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // bit i holds node i.
  typedef logic [NODES-1:0] net_state_t;

  typedef logic [COUNT_W-1:0] count_t;  // unsigned step count.

endpackage
